// ==== Bender.yml ====
package:
  name: cpu_subsystem

sources:
  - include_dirs:
      - design
    files:
      - design/isaPkg.sv
      - design/busPkg.sv
      - design/fetchUnit.sv
      - design/execCore.sv
      - design/memArbiter.sv
      - design/cpuTop.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - verif/cpuChecker.sv
      - verif/tbCpu.sv

// ==== design/busPkg.sv ====
`default_nettype none

`include "cpu_params.svh"

package busPkg;

    // request side of a four-phase memory link
    typedef struct packed {
        logic                  write;
        logic [`WORD_SIZE-1:0] addr;
        logic [`WORD_SIZE-1:0] wdata;
    } memReqS;

    // only valid while ack is high
    typedef struct packed {
        logic [`WORD_SIZE-1:0] rdata;
    } memRspS;

endpackage

`default_nettype wire

// ==== design/cpuTop.sv ====
`default_nettype none

`include "cpu_params.svh"

module cpuTop (
    input  logic                  clk,
    input  logic                  rst,
    output logic                  memReq,
    output busPkg::memReqS        memReqData,
    input  logic                  memAck,
    input  busPkg::memRspS        memRsp,
    output logic [`WORD_SIZE-1:0] outputPort,
    output logic                  outputValid,
    output logic [`WORD_SIZE-1:0] numInst,
    output logic                  halted
);

    logic                  instrValid;
    isaPkg::instrU         instrWord;
    logic [`WORD_SIZE-1:0] instrPc;
    logic                  instrTake;
    logic                  redirect;
    logic [`WORD_SIZE-1:0] redirectPc;

    logic                  fetchReq;
    busPkg::memReqS        fetchReqData;
    logic                  fetchAck;
    busPkg::memRspS        fetchRsp;
    logic                  dataReq;
    busPkg::memReqS        dataReqData;
    logic                  dataAck;
    busPkg::memRspS        dataRsp;

    fetchUnit uFetch (
        .clk          (clk),
        .rst          (rst),
        .redirect     (redirect),
        .redirectPc   (redirectPc),
        .halted       (halted),
        .instrTake    (instrTake),
        .instrValid   (instrValid),
        .instrWord    (instrWord),
        .instrPc      (instrPc),
        .fetchReq     (fetchReq),
        .fetchReqData (fetchReqData),
        .fetchAck     (fetchAck),
        .fetchRsp     (fetchRsp)
    );

    execCore uCore (
        .clk         (clk),
        .rst         (rst),
        .instrValid  (instrValid),
        .instrWord   (instrWord),
        .instrPc     (instrPc),
        .instrTake   (instrTake),
        .redirect    (redirect),
        .redirectPc  (redirectPc),
        .dataReq     (dataReq),
        .dataReqData (dataReqData),
        .dataAck     (dataAck),
        .dataRsp     (dataRsp),
        .outputPort  (outputPort),
        .outputValid (outputValid),
        .numInst     (numInst),
        .halted      (halted)
    );

    // single external port shared by instruction and data traffic
    memArbiter uArb (
        .clk          (clk),
        .rst          (rst),
        .fetchReq     (fetchReq),
        .fetchReqData (fetchReqData),
        .fetchAck     (fetchAck),
        .fetchRsp     (fetchRsp),
        .dataReq      (dataReq),
        .dataReqData  (dataReqData),
        .dataAck      (dataAck),
        .dataRsp      (dataRsp),
        .memReq       (memReq),
        .memReqData   (memReqData),
        .memAck       (memAck),
        .memRsp       (memRsp)
    );

endmodule

`default_nettype wire

// ==== design/cpu_params.svh ====
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// data, address and instruction width
`define WORD_SIZE 16

// architectural register file
`define NUM_REGS  4
`define REG_IDX_W 2

// immediate field of the I format, sign-extended to a word
`define IMM_W     8

`endif

// ==== design/execCore.sv ====
`default_nettype none

`include "cpu_params.svh"

module execCore (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  instrValid,
    input  isaPkg::instrU         instrWord,
    input  logic [`WORD_SIZE-1:0] instrPc,
    output logic                  instrTake,
    output logic                  redirect,
    output logic [`WORD_SIZE-1:0] redirectPc,
    output logic                  dataReq,
    output busPkg::memReqS        dataReqData,
    input  logic                  dataAck,
    input  busPkg::memRspS        dataRsp,
    output logic [`WORD_SIZE-1:0] outputPort,
    output logic                  outputValid,
    output logic [`WORD_SIZE-1:0] numInst,
    output logic                  halted
);

    // request phase also serves as idle
    typedef enum logic {dsRequest, dsRelease} dataStateE;

    dataStateE             dataState;
    logic [`WORD_SIZE-1:0] regFile [`NUM_REGS];
    logic [`WORD_SIZE-1:0] retireCount;
    logic [`WORD_SIZE-1:0] loadData;
    logic                  haltReg;

    isaPkg::opcodeE        op;
    isaPkg::funcE          fn;
    logic [`REG_IDX_W-1:0] rs;
    logic [`REG_IDX_W-1:0] rt;
    logic [`REG_IDX_W-1:0] rd;
    logic [`WORD_SIZE-1:0] immExt;
    logic [`WORD_SIZE-1:0] rsVal;
    logic [`WORD_SIZE-1:0] rtVal;
    logic [`WORD_SIZE-1:0] aluResult;
    logic                  isRgrp;
    logic                  isAluR;
    logic                  isMem;
    logic                  isWwd;
    logic                  isHlt;
    logic                  take;
    logic                  regWrite;

    assign op     = instrWord.r.opcode;
    assign fn     = instrWord.r.func;
    assign rs     = instrWord.i.rs;
    assign rt     = instrWord.i.rt;
    assign rd     = instrWord.r.rd;
    assign immExt = {{(`WORD_SIZE - `IMM_W){instrWord.i.imm[`IMM_W-1]}}, instrWord.i.imm};
    assign rsVal  = regFile[rs];
    assign rtVal  = regFile[rt];

    assign isRgrp = (op == isaPkg::opRgrp);
    assign isAluR = isRgrp && (fn inside {isaPkg::fnAdd, isaPkg::fnSub, isaPkg::fnAnd,
                                          isaPkg::fnOrr});
    assign isMem  = (op == isaPkg::opLwd) || (op == isaPkg::opSwd);
    assign isWwd  = isRgrp && (fn == isaPkg::fnWwd);
    assign isHlt  = isRgrp && (fn == isaPkg::fnHlt);

    // rs + imm unless R group, so loads and stores get their address here too
    always_comb begin
        aluResult = rsVal + immExt;
        if (isRgrp) begin
            case (fn)
                isaPkg::fnSub: aluResult = rsVal - rtVal;
                isaPkg::fnAnd: aluResult = rsVal & rtVal;
                isaPkg::fnOrr: aluResult = rsVal | rtVal;
                default:       aluResult = rsVal + rtVal;
            endcase
        end
    end

    // memory ops retire once ack has dropped, everything else right away
    always_comb begin
        take = 1'b0;
        if (instrValid && !haltReg)
            take = isMem ? (dataState == dsRelease && !dataAck) : 1'b1;
    end

    assign instrTake = take;
    assign regWrite  = take && (isAluR || op == isaPkg::opAdi || op == isaPkg::opLwd);

    assign redirect   = take && ((op == isaPkg::opJmp) || (op == isaPkg::opBne && rsVal != rtVal));
    assign redirectPc = (op == isaPkg::opJmp) ?
                        {instrPc[`WORD_SIZE-1:`WORD_SIZE-4], instrWord.j.target} :
                        instrPc + 1'b1 + immExt;

    // instruction stays in the fetch buffer, so the request is stable
    assign dataReq     = instrValid && isMem && !haltReg && (dataState == dsRequest);
    assign dataReqData = '{write: (op == isaPkg::opSwd), addr: aluResult, wdata: rtVal};

    always_ff @(posedge clk) begin
        if (rst)
            dataState <= dsRequest;
        else if (dataState == dsRequest && dataReq && dataAck)
            dataState <= dsRelease;
        else if (dataState == dsRelease && !dataAck)
            dataState <= dsRequest;
    end

    always_ff @(posedge clk) begin
        if (dataState == dsRequest && dataAck)
            loadData <= dataRsp.rdata;   // rsp is gone once ack falls
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `NUM_REGS; i++)
                regFile[i] <= '0;
        end else if (regWrite) begin
            if (isRgrp)
                regFile[rd] <= aluResult;
            else if (op == isaPkg::opLwd)
                regFile[rt] <= loadData;
            else
                regFile[rt] <= aluResult;   // ADI
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            retireCount <= '0;
            haltReg     <= 1'b0;
        end else begin
            if (take)
                retireCount <= retireCount + 1'b1;
            if (take && isHlt)
                haltReg <= 1'b1;
        end
    end

    assign outputPort  = rsVal;
    assign outputValid = take && isWwd;
    assign numInst     = retireCount + {{(`WORD_SIZE-1){1'b0}}, take};   // includes this one
    assign halted      = haltReg || (take && isHlt);

endmodule

`default_nettype wire

// ==== design/fetchUnit.sv ====
`default_nettype none

`include "cpu_params.svh"

module fetchUnit (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  redirect,
    input  logic [`WORD_SIZE-1:0] redirectPc,
    input  logic                  halted,
    input  logic                  instrTake,
    output logic                  instrValid,
    output isaPkg::instrU         instrWord,
    output logic [`WORD_SIZE-1:0] instrPc,
    output logic                  fetchReq,
    output busPkg::memReqS        fetchReqData,
    input  logic                  fetchAck,
    input  busPkg::memRspS        fetchRsp
);

    typedef enum logic [1:0] {fsIdle, fsWaitAck, fsWaitDrop, fsDiscard} fetchStateE;

    fetchStateE            state;
    logic [`WORD_SIZE-1:0] pc;       // next address to fetch
    logic [`WORD_SIZE-1:0] reqPc;    // address of the fetch in flight
    logic                  bufValid;
    isaPkg::instrU         bufWord;
    logic [`WORD_SIZE-1:0] bufPc;
    logic                  issue;
    logic                  capture;

    // never fetch past a buffer that stays full this cycle
    assign issue   = (state == fsIdle) && !halted && !redirect && (!bufValid || instrTake);
    assign capture = (state == fsWaitAck) && fetchAck && !redirect;

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= fsIdle;
            pc       <= '0;
            bufValid <= 1'b0;
        end else begin
            case (state)
                fsIdle: if (issue) state <= fsWaitAck;
                fsWaitAck: begin
                    if (fetchAck)
                        state <= fsWaitDrop;
                    else if (redirect)
                        state <= fsDiscard;   // finish the handshake, drop the word
                end
                fsDiscard: if (fetchAck) state <= fsWaitDrop;
                fsWaitDrop: if (!fetchAck) state <= fsIdle;
                default: state <= fsIdle;
            endcase

            if (redirect)
                pc <= redirectPc;
            else if (issue)
                pc <= pc + 1'b1;

            if (redirect)
                bufValid <= 1'b0;   // flush the prefetched word
            else if (capture)
                bufValid <= 1'b1;
            else if (instrTake)
                bufValid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (issue)
            reqPc <= pc;
        if (capture) begin
            bufWord <= fetchRsp.rdata;
            bufPc   <= reqPc;
        end
    end

    assign fetchReq     = (state == fsWaitAck) || (state == fsDiscard);
    assign fetchReqData = '{write: 1'b0, addr: reqPc, wdata: '0};

    assign instrValid = bufValid;
    assign instrWord  = bufWord;
    assign instrPc    = bufPc;

endmodule

`default_nettype wire

// ==== design/isaPkg.sv ====
`default_nettype none

`include "cpu_params.svh"

package isaPkg;

    typedef enum logic [3:0] {
        opBne  = 4'd0,
        opAdi  = 4'd4,
        opLwd  = 4'd7,
        opSwd  = 4'd8,
        opJmp  = 4'd9,
        opRgrp = 4'd15   // func field selects the operation
    } opcodeE;

    typedef enum logic [5:0] {
        fnAdd = 6'd0,
        fnSub = 6'd1,
        fnAnd = 6'd2,
        fnOrr = 6'd3,
        fnWwd = 6'd28,
        fnHlt = 6'd29
    } funcE;

    typedef struct packed {
        opcodeE                opcode;
        logic [`REG_IDX_W-1:0] rs;
        logic [`REG_IDX_W-1:0] rt;
        logic [`REG_IDX_W-1:0] rd;
        funcE                  func;
    } rFormatS;

    typedef struct packed {
        opcodeE                opcode;
        logic [`REG_IDX_W-1:0] rs;
        logic [`REG_IDX_W-1:0] rt;
        logic [`IMM_W-1:0]     imm;
    } iFormatS;

    typedef struct packed {
        opcodeE                opcode;
        logic [`WORD_SIZE-5:0] target;   // low 12 bits of the jump address
    } jFormatS;

    // one fetched word, read through whichever format its opcode implies
    typedef union packed {
        rFormatS r;
        iFormatS i;
        jFormatS j;
    } instrU;

endpackage

`default_nettype wire

// ==== design/memArbiter.sv ====
`default_nettype none

module memArbiter (
    input  logic           clk,
    input  logic           rst,
    input  logic           fetchReq,
    input  busPkg::memReqS fetchReqData,
    output logic           fetchAck,
    output busPkg::memRspS fetchRsp,
    input  logic           dataReq,
    input  busPkg::memReqS dataReqData,
    output logic           dataAck,
    output busPkg::memRspS dataRsp,
    output logic           memReq,
    output busPkg::memReqS memReqData,
    input  logic           memAck,
    input  busPkg::memRspS memRsp
);

    typedef enum logic [1:0] {ownNone, ownFetch, ownData} ownerE;

    ownerE owner;
    logic  portIdle;
    logic  grantData;
    logic  grantFetch;

    assign portIdle = (owner == ownNone) && !memAck;

    // new grants pass through in the same cycle, data wins a tie
    assign grantData  = (owner == ownData) || (portIdle && dataReq);
    assign grantFetch = (owner == ownFetch) || (portIdle && !dataReq && fetchReq);

    assign memReq     = (grantData && dataReq) || (grantFetch && fetchReq);
    assign memReqData = grantData ? dataReqData : fetchReqData;

    assign dataAck  = grantData && memAck;
    assign fetchAck = grantFetch && memAck;
    assign dataRsp  = grantData ? memRsp : '0;
    assign fetchRsp = grantFetch ? memRsp : '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            owner <= ownNone;
        end else if (portIdle) begin
            if (dataReq)
                owner <= ownData;
            else if (fetchReq)
                owner <= ownFetch;
        end else if (owner != ownNone && !memReq && !memAck) begin
            owner <= ownNone;   // handshake back at idle
        end
    end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+design
design/isaPkg.sv
design/busPkg.sv
design/fetchUnit.sv
design/execCore.sv
design/memArbiter.sv
design/cpuTop.sv
verif/cpuChecker.sv
verif/tbCpu.sv

// ==== verif/cpuChecker.sv ====
`default_nettype none

`include "cpu_params.svh"

module cpuChecker (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  memReq,
    input  busPkg::memReqS        memReqData,
    input  logic                  memAck,
    input  logic [`WORD_SIZE-1:0] outputPort,
    input  logic                  outputValid,
    input  logic [`WORD_SIZE-1:0] numInst,
    input  logic                  halted,
    output int                    errorCount,
    output int                    outCount,
    output int                    expCount
);

    logic [`WORD_SIZE-1:0] image [256];   // same image the memory model loads
    logic                  prevReq;
    logic                  prevAck;
    logic                  prevHalted;
    busPkg::memReqS        prevData;
    logic [`WORD_SIZE-1:0] expValue;
    logic [`WORD_SIZE-1:0] expRetire;

    task automatic reportFault(input string msg);
        errorCount++;
        $display("error at %0t: %s", $time, msg);
    endtask

    task automatic checkValue(input string what, input logic [`WORD_SIZE-1:0] got,
                              input logic [`WORD_SIZE-1:0] want);
        if (got !== want) begin
            errorCount++;
            $display("mismatch at %0t: %s is %h, expected %h", $time, what, got, want);
        end
    endtask

    initial begin
        errorCount = 0;
        outCount   = 0;
        $readmemh("verif/program_patterns.hex", image);
        expCount   = image['hC0];
    end

    // sampled mid-cycle while the DUT outputs are settled
    always @(negedge clk) begin
        if (rst) begin
            prevReq    = 1'b0;
            prevAck    = 1'b0;
            prevHalted = 1'b0;
        end else begin
            if (prevReq && !memReq && !prevAck)
                reportFault("memReq dropped before memAck");
            if (!prevReq && memReq && memAck)
                reportFault("memReq raised while memAck still high");
            if (prevReq && memReq && !prevAck && memReqData !== prevData)
                reportFault("memory request changed while waiting for memAck");
            if (prevHalted && memReq && !prevReq)
                reportFault("new memory request after halt");

            if (outputValid) begin
                if (prevHalted) begin
                    reportFault("output after halt");
                end else if (outCount >= expCount) begin
                    reportFault($sformatf("extra output %h, only %0d expected",
                                          outputPort, expCount));
                end else begin
                    expValue  = image['hC1 + 2 * outCount];
                    expRetire = image['hC2 + 2 * outCount];
                    checkValue($sformatf("output %0d value", outCount),
                               outputPort, expValue);
                    checkValue($sformatf("output %0d retire count", outCount),
                               numInst, expRetire);
                end
                outCount++;
            end

            if (prevHalted && !halted)
                reportFault("halted dropped after it was raised");
            if (halted && !prevHalted && outCount != expCount)
                reportFault($sformatf("halted after %0d of %0d outputs", outCount, expCount));

            prevReq    = memReq;
            prevAck    = memAck;
            prevHalted = halted;
            prevData   = memReqData;
        end
    end

endmodule

`default_nettype wire

// ==== verif/program_patterns.hex ====
// program and data words, several per line, @ sets the word address
// from c0 the count of expected results, then pairs of output value and retire count
@00
4105 4203 F6C0 FC1C   // adi r1 5 / adi r2 3 / add r3 / wwd r3
F6C1 FC1C F6C2 FC1C   // sub / wwd / and / wwd
F6C3 FC1C 45FE F41C   // orr / wwd / adi r1 -2 / wwd r1
7260 F81C F9C0 8361   // lwd r2 [60] / wwd r2 / add r3 / swd r3 [61]
7161 F41C 0601 F41C   // lwd r1 [61] / wwd r1 / bne taken / skipped wwd
0D02 4011 F01C 901A   // bne not taken / adi r0 11 / wwd r0 / jmp 1a
F41C F01D             // jumped over
FFC1 42F1 4AFF F81C   // r3 = 0 / r2 = 2 / loop at 1c decrements r2 / wwd r2
0BFD F01D             // bne back to 1c / hlt
@60
1234 DEAD             // preloaded word and store target
@C0
000A
0008 0004
0002 0006
0001 0008
0007 000A
0003 000C
1234 000E
1237 0012
0011 0016
0001 001B
0000 001E

// ==== verif/tbCpu.sv ====
`default_nettype none

`include "cpu_params.svh"

module tbCpu;

    logic                  clk = 1'b0;
    logic                  rst;
    logic                  memReq;
    busPkg::memReqS        memReqData;
    logic                  memAck;
    busPkg::memRspS        memRsp;
    logic [`WORD_SIZE-1:0] outputPort;
    logic                  outputValid;
    logic [`WORD_SIZE-1:0] numInst;
    logic                  halted;
    int                    errorCount;
    int                    outCount;
    int                    expCount;

    logic [`WORD_SIZE-1:0] mem [256];   // external memory, word addressed
    integer                seed = 78;
    logic                  reqSeen;     // memReq as seen mid-cycle
    busPkg::memReqS        reqSnap;

    always #5 clk = ~clk;

    cpuTop dut (
        .clk         (clk),
        .rst         (rst),
        .memReq      (memReq),
        .memReqData  (memReqData),
        .memAck      (memAck),
        .memRsp      (memRsp),
        .outputPort  (outputPort),
        .outputValid (outputValid),
        .numInst     (numInst),
        .halted      (halted)
    );

    cpuChecker chk (
        .clk         (clk),
        .rst         (rst),
        .memReq      (memReq),
        .memReqData  (memReqData),
        .memAck      (memAck),
        .outputPort  (outputPort),
        .outputValid (outputValid),
        .numInst     (numInst),
        .halted      (halted),
        .errorCount  (errorCount),
        .outCount    (outCount),
        .expCount    (expCount)
    );

    // background for words the image leaves unset
    function automatic logic [`WORD_SIZE-1:0] fillWord(input logic [7:0] addr);
        return {addr, ~addr};
    endfunction

    task automatic finishRun(input bit timedOut);
        int total;
        total = errorCount + (timedOut ? 1 : 0);
        $display("summary: %0d errors, %0d of %0d outputs seen", total, outCount, expCount);
        if (total == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    endtask

    always @(negedge clk) begin
        reqSeen <= memReq;
        reqSnap <= memReqData;
    end

    // four-phase responder with a random wait before each ack
    initial begin : memModel
        int             delay;
        busPkg::memReqS req;
        for (int a = 0; a < 256; a++)
            mem[a] = fillWord(a[7:0]);
        $readmemh("verif/program_patterns.hex", mem);
        memAck = 1'b0;
        memRsp = '0;
        forever begin
            @(posedge clk);
            #1;
            if (!rst && reqSeen) begin
                delay = $unsigned($random(seed)) % 8;
                for (int k = 0; k < delay; k++) begin
                    @(posedge clk);
                    #1;
                end
                req = reqSnap;
                if (req.write)
                    mem[req.addr[7:0]] = req.wdata;
                memRsp = '{rdata: mem[req.addr[7:0]]};
                memAck = 1'b1;
                do begin
                    @(posedge clk);
                    #1;
                end while (reqSeen);   // hold ack until req is gone
                memAck = 1'b0;
                memRsp = '0;
            end
        end
    end

    initial begin : mainFlow
        rst = 1'b1;
        repeat (8) @(posedge clk);
        #1 rst = 1'b0;
        while (halted !== 1'b1)
            @(negedge clk);
        repeat (20) @(posedge clk);   // quiet time to catch late activity
        finishRun(1'b0);
    end

    initial begin : watchdog
        int used;
        int limit;
        @(negedge rst);
        used = 0;
        for (int a = 0; a < 'hC0; a++)
            if (mem[a] !== fillWord(a[7:0]))
                used++;   // program and data words
        limit = (used + 2 * int'(mem['hC0])) * 12 * 2 * 10;
        #(limit);
        $display("timeout: processor did not halt within %0d time units", limit);
        finishRun(1'b1);
    end

endmodule

`default_nettype wire
